// File: vlog.f
+incdir+tests
rtl/dbg_trig_pkg.sv
rtl/trig_csr_wr_if.sv
rtl/trig_csr_regs.sv
rtl/trig_exec_match.sv
rtl/trig_lsu_match.sv
rtl/trig_exc_match.sv
rtl/dbg_triggers.sv
tests/tb_dbg_triggers.sv

// File: tests/tb_trig_model.svh
//////////////////////////////
// Reference model of the trigger CSRs and the three match rules
// Included inside the testbench module after NUM_TRIGGERS is known
//////////////////////////////
`ifndef TB_TRIG_MODEL_SVH
`define TB_TRIG_MODEL_SVH

logic [31:0] m_tselect;                // Model copy of the registers
logic [31:0] m_tdata1 [NUM_TRIGGERS];
logic [31:0] m_tdata2 [NUM_TRIGGERS];

task automatic model_reset();
  m_tselect = '0;
  for (int i = 0; i < NUM_TRIGGERS; i++) begin
    m_tdata1[i] = 32'hF800_0000;  // Disabled, dmode set
    m_tdata2[i] = '0;
  end
endtask

// One CSR write, we is {tdata2, tdata1, tselect}
task automatic model_write(input logic [2:0] we, input logic [31:0] wd);
  logic [31:0] t1;
  logic [3:0]  mode;
  t1   = m_tdata1[m_tselect];
  mode = (wd[10:7] inside {4'd0, 4'd2, 4'd3}) ? wd[10:7] : 4'd0;  // Illegal modes become EQ
  if (we[0] && (wd < NUM_TRIGGERS)) m_tselect = wd;
  if (we[1]) begin
    if (wd[31:28] == 4'd6)
      m_tdata1[m_tselect] = {4'd6, 1'b1, 11'd0, 4'd1, 1'b0, mode, wd[6], 2'b0, wd[3], wd[2:0]};
    else if ((wd[31:28] == 4'd5) && ((m_tdata2[m_tselect] & ~32'h0100_09AE) == '0))
      m_tdata1[m_tselect] = {4'd5, 1'b1, 17'd0, wd[9], 2'b0, wd[6], 6'd1};
    else
      m_tdata1[m_tselect] = 32'hF800_0000;
  end
  if (we[2]) m_tdata2[m_tselect] = (t1[31:28] == 4'd5) ? (wd & 32'h0100_09AE) : wd;
endtask

function automatic logic lvl_ok(input logic m_en, input logic u_en, input logic [1:0] lvl);
  return (m_en && (lvl == 2'b11)) || (u_en && (lvl == 2'b00));
endfunction

// GE looks at the last byte, LT at the first, anything else is the equality result
function automatic logic addr_cmp(input logic [3:0] mode, input logic [31:0] lo,
                                  input logic [31:0] hi, input logic [31:0] t2, input logic eq);
  case (mode)
    4'd2:    return hi >= t2;
    4'd3:    return lo < t2;
    default: return eq;
  endcase
endfunction

function automatic logic [NUM_TRIGGERS-1:0] exec_expect(input logic [31:0] pc,
                                                        input logic [1:0] lvl, input logic dbg);
  logic [NUM_TRIGGERS-1:0] res;
  for (int t = 0; t < NUM_TRIGGERS; t++) begin
    res[t] = (m_tdata1[t][31:28] == 4'd6) && m_tdata1[t][2] && !dbg &&
             lvl_ok(m_tdata1[t][6], m_tdata1[t][3], lvl) &&
             addr_cmp(m_tdata1[t][10:7], pc, pc, m_tdata2[t], pc == m_tdata2[t]);
  end
  return res;
endfunction

function automatic logic [NUM_TRIGGERS-1:0] lsu_expect(input logic valid, input logic [31:0] addr,
    input logic we, input logic [3:0] be, input logic [1:0] lvl, input logic dbg);
  logic [NUM_TRIGGERS-1:0] res;
  logic [1:0]              lo;
  logic [1:0]              hi;
  lo = be[0] ? 2'd0 : be[1] ? 2'd1 : be[2] ? 2'd2 : 2'd3;  // Byte enables never all zero
  hi = be[3] ? 2'd3 : be[2] ? 2'd2 : be[1] ? 2'd1 : 2'd0;
  for (int t = 0; t < NUM_TRIGGERS; t++) begin
    res[t] = (m_tdata1[t][31:28] == 4'd6) && valid && !dbg &&
             (we ? m_tdata1[t][1] : m_tdata1[t][0]) &&
             lvl_ok(m_tdata1[t][6], m_tdata1[t][3], lvl) &&
             addr_cmp(m_tdata1[t][10:7], {addr[31:2], lo}, {addr[31:2], hi}, m_tdata2[t],
                      (addr[31:2] == m_tdata2[t][31:2]) && be[m_tdata2[t][1:0]]);
  end
  return res;
endfunction

function automatic logic exc_expect(input logic exc, input logic [10:0] cause,
                                    input logic [1:0] lvl, input logic dbg);
  logic hit;
  hit = 1'b0;
  for (int t = 0; t < NUM_TRIGGERS; t++) begin
    hit |= (m_tdata1[t][31:28] == 4'd5) && exc && (cause < 32) && m_tdata2[t][cause[4:0]] &&
           lvl_ok(m_tdata1[t][9], m_tdata1[t][6], lvl);  // Etrigger m and u positions
  end
  return hit && !dbg;
endfunction

`endif

// File: tests/tb_dbg_triggers.sv
//////////////////////////////
// Random testbench of the debug trigger unit
// CSR writes and pipeline inputs from a fixed seed, checked every cycle
//////////////////////////////
`default_nettype none

module tb_dbg_triggers
  import dbg_trig_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TRIGGERS = 2;
  localparam int ITERS        = 300;  // Cycles per phase
  localparam int PHASES       = 4;    // tselect, config, address match, etrigger

  logic                    clk;
  logic                    arst_n;
  logic [31:0]             csr_wdata;
  logic                    tselect_we, tdata1_we, tdata2_we;
  logic [31:0]             tselect_rdata, tdata1_rdata, tdata2_rdata, tinfo_rdata;
  logic [31:0]             pc_if, lsu_addr;
  priv_lvl_t               priv_if, priv_ex, priv_wb;
  logic                    lsu_valid, lsu_we, exc_wb, debug_mode;
  logic [3:0]              lsu_be;
  logic [10:0]             exc_cause;
  logic [NUM_TRIGGERS-1:0] match_if, match_ex;
  logic                    etrig_wb;
  integer                  seed   = 1;
  int                      errors = 0;
  int                      checks = 0;

  `include "tb_trig_model.svh"

  dbg_triggers #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_dbg_triggers (
    .clk_i(clk), .arst_n_i(arst_n), .csr_wdata_i(csr_wdata), .tselect_we_i(tselect_we),
    .tdata1_we_i(tdata1_we), .tdata2_we_i(tdata2_we), .tselect_rdata_o(tselect_rdata),
    .tdata1_rdata_o(tdata1_rdata), .tdata2_rdata_o(tdata2_rdata), .tinfo_rdata_o(tinfo_rdata),
    .pc_if_i(pc_if), .priv_lvl_if_i(priv_if), .lsu_valid_ex_i(lsu_valid),
    .lsu_addr_ex_i(lsu_addr), .lsu_we_ex_i(lsu_we), .lsu_be_ex_i(lsu_be),
    .priv_lvl_ex_i(priv_ex), .priv_lvl_wb_i(priv_wb), .exception_in_wb_i(exc_wb),
    .exception_cause_wb_i(exc_cause), .debug_mode_i(debug_mode),
    .trigger_match_if_o(match_if), .trigger_match_ex_o(match_ex), .etrigger_wb_o(etrig_wb));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    #((PHASES * ITERS + 20) * 100);  // Every phase cycle plus slack for reset
    $display("Watchdog expired before the test sequence completed");
    $display("Test FAILED");
    $finish;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_outputs();
    compare_value("tselect_rdata_o", m_tselect, tselect_rdata);
    compare_value("tdata1_rdata_o", m_tdata1[m_tselect], tdata1_rdata);
    compare_value("tdata2_rdata_o", m_tdata2[m_tselect], tdata2_rdata);
    compare_value("tinfo_rdata_o", 32'h0100_8060, tinfo_rdata);  // Types 5, 6, 15
    compare_value("trigger_match_if_o", 32'(exec_expect(pc_if, priv_if, debug_mode)),
                  32'(match_if));
    compare_value("trigger_match_ex_o",
                  32'(lsu_expect(lsu_valid, lsu_addr, lsu_we, lsu_be, priv_ex, debug_mode)),
                  32'(match_ex));
    compare_value("etrigger_wb_o", 32'(exc_expect(exc_wb, exc_cause, priv_wb, debug_mode)),
                  32'(etrig_wb));
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_random(input int phase);
    int kind;
    int t;
    int r;
    kind       = $unsigned($random(seed)) % ((phase < 2) ? 4 : 12);  // Sparse writes later on
    t          = $unsigned($random(seed)) % NUM_TRIGGERS;
    r          = $random(seed);
    tselect_we = (phase == 0) || (kind == 0);
    tdata1_we  = (phase != 0) && ((kind == 1) || (kind == 2));
    tdata2_we  = (phase != 0) && (kind == 3);
    csr_wdata  = $random(seed);
    if (tselect_we) csr_wdata = {29'd0, csr_wdata[2:0]};  // Also past the last trigger
    if (tdata1_we) begin
      case (r[22:21])
        2'd0: csr_wdata[31:28] = 4'd6;
        2'd1: csr_wdata[31:28] = (phase == 3) ? 4'd5 : 4'd6;
        2'd2: csr_wdata[31:28] = 4'd5;
        default: ;  // Whatever type the random word holds
      endcase
    end
    if (tdata2_we && r[23]) csr_wdata = csr_wdata & 32'h0100_09AE;  // Legal etrigger causes
    pc_if      = r[0] ? m_tdata2[t] : $random(seed);  // Half the PCs sit on a breakpoint
    lsu_addr   = r[1] ? {m_tdata2[t][31:2], r[9:8]} : $random(seed);
    lsu_be     = (r[7:4] == 4'd0) ? 4'b0001 : r[7:4];
    lsu_valid  = r[2];
    lsu_we     = r[3];
    exc_wb     = r[10];
    exc_cause  = 11'(r[31:24] % 40);  // Some causes beyond 31
    priv_if    = priv_lvl_t'(r[12:11]);
    priv_ex    = priv_lvl_t'(r[14:13]);
    priv_wb    = priv_lvl_t'(r[16:15]);
    debug_mode = (r[19:17] == 3'd0);  // One cycle in eight
  endtask

  initial begin
    arst_n     = 1'b0;
    csr_wdata  = '0;
    {tselect_we, tdata1_we, tdata2_we} = '0;
    pc_if      = '0;
    lsu_addr   = '0;
    lsu_be     = 4'b0001;
    {lsu_valid, lsu_we, exc_wb, debug_mode} = '0;
    exc_cause  = '0;
    priv_if    = PRIV_LVL_M;
    priv_ex    = PRIV_LVL_M;
    priv_wb    = PRIV_LVL_M;
    model_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #20;
    check_outputs();  // Reset values with idle inputs
    for (int p = 0; p < PHASES; p++) begin
      repeat (ITERS) begin
        @(negedge clk);
        drive_random(p);
        #20;
        check_outputs();
        @(posedge clk);
        model_write({tdata2_we, tdata1_we, tselect_we}, csr_wdata);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dbg_triggers.sv
//////////////////////////////
// Debug trigger unit top level with plain CSR and pipeline ports
//////////////////////////////
`default_nettype none

module dbg_triggers
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2  // 1 to 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,

  // CSR write side
  input  wire logic [XLEN-1:0]        csr_wdata_i,
  input  wire logic                   tselect_we_i,
  input  wire logic                   tdata1_we_i,
  input  wire logic                   tdata2_we_i,

  // CSR read side
  output logic [XLEN-1:0]             tselect_rdata_o,
  output logic [XLEN-1:0]             tdata1_rdata_o,
  output logic [XLEN-1:0]             tdata2_rdata_o,
  output logic [XLEN-1:0]             tinfo_rdata_o,

  input  wire logic [XLEN-1:0]        pc_if_i,              // IF stage
  input  wire priv_lvl_t              priv_lvl_if_i,
  input  wire logic                   lsu_valid_ex_i,       // EX stage
  input  wire logic [XLEN-1:0]        lsu_addr_ex_i,
  input  wire logic                   lsu_we_ex_i,
  input  wire logic [3:0]             lsu_be_ex_i,
  input  wire priv_lvl_t              priv_lvl_ex_i,
  input  wire priv_lvl_t              priv_lvl_wb_i,        // WB stage
  input  wire logic                   exception_in_wb_i,
  input  wire logic [EXC_CAUSE_W-1:0] exception_cause_wb_i,
  input  wire logic                   debug_mode_i,

  output logic [NUM_TRIGGERS-1:0]     trigger_match_if_o,  // Instruction address hits
  output logic [NUM_TRIGGERS-1:0]     trigger_match_ex_o,  // Load/store address hits
  output logic                        etrigger_wb_o        // Exception trigger hit
);

  tdata1_u         tdata1_q [NUM_TRIGGERS];
  logic [XLEN-1:0] tdata2_q [NUM_TRIGGERS];

  trig_csr_wr_if csr_wr ();

  // Master side of the write bundle
  assign csr_wr.wdata      = csr_wdata_i;
  assign csr_wr.tselect_we = tselect_we_i;
  assign csr_wr.tdata1_we  = tdata1_we_i;
  assign csr_wr.tdata2_we  = tdata2_we_i;

  assign tinfo_rdata_o = TINFO_VALUE;  // Read only

  trig_csr_regs #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_csr_regs (
    .clk_i, .arst_n_i, .wr_if(csr_wr.slave), .tselect_rdata_o, .tdata1_rdata_o,
    .tdata2_rdata_o, .tdata1_q_o(tdata1_q), .tdata2_q_o(tdata2_q));

  trig_exec_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_exec_match (
    .tdata1_i(tdata1_q), .tdata2_i(tdata2_q), .pc_if_i, .priv_lvl_if_i, .debug_mode_i,
    .match_o(trigger_match_if_o));

  trig_lsu_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_lsu_match (
    .tdata1_i(tdata1_q), .tdata2_i(tdata2_q), .lsu_valid_i(lsu_valid_ex_i),
    .lsu_addr_i(lsu_addr_ex_i), .lsu_we_i(lsu_we_ex_i), .lsu_be_i(lsu_be_ex_i),
    .priv_lvl_i(priv_lvl_ex_i), .debug_mode_i, .match_o(trigger_match_ex_o));

  trig_exc_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_exc_match (
    .tdata1_i(tdata1_q), .tdata2_i(tdata2_q), .exception_in_wb_i, .exception_cause_wb_i,
    .priv_lvl_wb_i, .debug_mode_i, .etrigger_o(etrigger_wb_o));

endmodule

`default_nettype wire

// File: rtl/trig_exc_match.sv
//////////////////////////////
// Exception trigger on the writeback exception cause
// ORs all etrigger hits into one flag
//////////////////////////////
`default_nettype none

module trig_exc_match
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  wire tdata1_u                tdata1_i [NUM_TRIGGERS],
  input  wire logic [XLEN-1:0]        tdata2_i [NUM_TRIGGERS],
  input  wire logic                   exception_in_wb_i,
  input  wire logic [EXC_CAUSE_W-1:0] exception_cause_wb_i,
  input  wire priv_lvl_t              priv_lvl_wb_i,
  input  wire logic                   debug_mode_i,
  output logic                        etrigger_o
);

  localparam int IDX_W = $clog2(XLEN);  // Cause bits that index tdata2

  logic                    cause_ok;  // Cause fits inside tdata2
  logic [NUM_TRIGGERS-1:0] hit;

  assign cause_ok = exception_in_wb_i && (exception_cause_wb_i[EXC_CAUSE_W-1:IDX_W] == '0);

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : gen_trig
    assign hit[t] = (tdata1_i[t].etrig.ttype == TTYPE_ETRIGGER) && cause_ok &&
                    tdata2_i[t][exception_cause_wb_i[IDX_W-1:0]] &&
                    priv_enabled(tdata1_i[t].etrig.m, tdata1_i[t].etrig.u, priv_lvl_wb_i);
  end

  assign etrigger_o = (|hit) && !debug_mode_i;

  always_comb begin
    a_exc_needs_wb: assert final (!etrigger_o || (exception_in_wb_i && !debug_mode_i));
  end

endmodule

`default_nettype wire

// File: rtl/trig_lsu_match.sv
//////////////////////////////
// Load/store address match on the LSU access in EX
// Uses the byte enables to find the touched address span
//////////////////////////////
`default_nettype none

module trig_lsu_match
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  wire tdata1_u            tdata1_i [NUM_TRIGGERS],
  input  wire logic [XLEN-1:0]    tdata2_i [NUM_TRIGGERS],
  input  wire logic               lsu_valid_i,
  input  wire logic [XLEN-1:0]    lsu_addr_i,
  input  wire logic               lsu_we_i,    // 1 is a store
  input  wire logic [3:0]         lsu_be_i,
  input  wire priv_lvl_t          priv_lvl_i,
  input  wire logic               debug_mode_i,
  output logic [NUM_TRIGGERS-1:0] match_o
);

  logic [1:0]      be_low;     // Lowest enabled byte
  logic [1:0]      be_high;    // Highest enabled byte
  logic [XLEN-1:0] addr_low;   // First byte touched
  logic [XLEN-1:0] addr_high;  // Last byte touched

  //////////////////////////////
  // Access span
  //////////////////////////////

  always_comb begin
    be_low  = 2'd0;
    be_high = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_i[b]) begin
        be_high = 2'(b);  // Last one set wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_i[b]) begin
        be_low = 2'(b);
      end
    end
  end

  assign addr_low  = {lsu_addr_i[XLEN-1:2], be_low};
  assign addr_high = {lsu_addr_i[XLEN-1:2], be_high};

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : gen_trig
    logic byte_hit;   // Some enabled byte sits at tdata2[1:0]
    logic addr_hit;
    logic dir_en;     // Load or store enabled for this direction

    assign byte_hit = |(lsu_be_i & (4'b0001 << tdata2_i[t][1:0]));

    always_comb begin
      case (tdata1_i[t].mc6.match)
        MATCH_GE: addr_hit = (addr_high >= tdata2_i[t]);
        MATCH_LT: addr_hit = (addr_low  <  tdata2_i[t]);
        default:  addr_hit = (lsu_addr_i[XLEN-1:2] == tdata2_i[t][XLEN-1:2]) && byte_hit;
      endcase
    end

    assign dir_en = (tdata1_i[t].mc6.load && !lsu_we_i) || (tdata1_i[t].mc6.store && lsu_we_i);

    assign match_o[t] = (tdata1_i[t].mc6.ttype == TTYPE_MCONTROL6) && lsu_valid_i && dir_en &&
                        priv_enabled(tdata1_i[t].mc6.m, tdata1_i[t].mc6.u, priv_lvl_i) &&
                        !debug_mode_i && addr_hit;
  end

  always_comb begin
    a_no_idle_match: assert final (lsu_valid_i || (match_o == '0));
  end

endmodule

`default_nettype wire

// File: rtl/trig_exec_match.sv
//////////////////////////////
// Instruction address match on the fetch PC
// One combinational match bit per trigger
//////////////////////////////
`default_nettype none

module trig_exec_match
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  wire tdata1_u            tdata1_i [NUM_TRIGGERS],
  input  wire logic [XLEN-1:0]    tdata2_i [NUM_TRIGGERS],
  input  wire logic [XLEN-1:0]    pc_if_i,
  input  wire priv_lvl_t          priv_lvl_if_i,
  input  wire logic               debug_mode_i,
  output logic [NUM_TRIGGERS-1:0] match_o
);

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : gen_trig
    logic addr_hit;  // PC versus tdata2 by match mode

    always_comb begin
      case (tdata1_i[t].mc6.match)
        MATCH_GE: addr_hit = (pc_if_i >= tdata2_i[t]);
        MATCH_LT: addr_hit = (pc_if_i <  tdata2_i[t]);
        default:  addr_hit = (pc_if_i == tdata2_i[t]);  // Only EQ is left after WARL
      endcase
    end

    assign match_o[t] = (tdata1_i[t].mc6.ttype == TTYPE_MCONTROL6) &&
                        tdata1_i[t].mc6.execute &&
                        priv_enabled(tdata1_i[t].mc6.m, tdata1_i[t].mc6.u, priv_lvl_if_i) &&
                        !debug_mode_i && addr_hit;
  end

  // Debug mode never sees its own breakpoints
  always_comb begin
    a_no_dbg_match: assert final (!(debug_mode_i && (|match_o)));
  end

endmodule

`default_nettype wire

// File: rtl/trig_csr_regs.sv
//////////////////////////////
// tselect, tdata1 and tdata2 of every trigger with WARL write rules
// Feeds the read mux and all match units
//////////////////////////////
`default_nettype none

module trig_csr_regs
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  trig_csr_wr_if.slave         wr_if,

  output logic [XLEN-1:0]      tselect_rdata_o,
  output logic [XLEN-1:0]      tdata1_rdata_o,
  output logic [XLEN-1:0]      tdata2_rdata_o,

  output tdata1_u              tdata1_q_o [NUM_TRIGGERS],  // To match units
  output logic [XLEN-1:0]      tdata2_q_o [NUM_TRIGGERS]
);

  logic [XLEN-1:0] tselect_q;
  tdata1_u         tdata1_q [NUM_TRIGGERS];
  logic [XLEN-1:0] tdata2_q [NUM_TRIGGERS];

  tdata1_u         tdata1_sel;   // Selected trigger
  logic [XLEN-1:0] tdata2_sel;
  tdata1_u         wr_view;      // Write data seen as tdata1
  tdata1_u         tdata1_n;     // WARL resolved tdata1
  logic [XLEN-1:0] tdata2_n;     // WARL resolved tdata2

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    tdata1_sel = tdata1_q[0];
    tdata2_sel = tdata2_q[0];
    for (int i = 1; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == i) begin
        tdata1_sel = tdata1_q[i];
        tdata2_sel = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;
  assign tdata1_rdata_o  = tdata1_sel.raw;
  assign tdata2_rdata_o  = tdata2_sel;

  //////////////////////////////
  // WARL resolution
  //////////////////////////////

  assign wr_view.raw = wr_if.wdata;

  always_comb begin
    tdata1_n.raw = TDATA1_DISABLED;  // Unknown types fall back to disabled
    case (wr_view.mc6.ttype)
      TTYPE_MCONTROL6: begin
        tdata1_n.raw         = '0;
        tdata1_n.mc6.ttype   = TTYPE_MCONTROL6;
        tdata1_n.mc6.dmode   = 1'b1;
        tdata1_n.mc6.action  = 4'd1;           // Enter debug mode
        tdata1_n.mc6.m       = wr_view.mc6.m;
        tdata1_n.mc6.u       = wr_view.mc6.u;
        tdata1_n.mc6.execute = wr_view.mc6.execute;
        tdata1_n.mc6.store   = wr_view.mc6.store;
        tdata1_n.mc6.load    = wr_view.mc6.load;
        // Only EQ, GE and LT survive
        if (wr_view.mc6.match inside {MATCH_EQ, MATCH_GE, MATCH_LT}) begin
          tdata1_n.mc6.match = wr_view.mc6.match;
        end else begin
          tdata1_n.mc6.match = MATCH_EQ;
        end
      end
      TTYPE_ETRIGGER: begin
        // Current tdata2 must only hold supported causes
        if ((tdata2_sel & ~ETRIG_CAUSE_MASK) == '0) begin
          tdata1_n.raw          = '0;
          tdata1_n.etrig.ttype  = TTYPE_ETRIGGER;
          tdata1_n.etrig.dmode  = 1'b1;
          tdata1_n.etrig.m      = wr_view.etrig.m;
          tdata1_n.etrig.u      = wr_view.etrig.u;
          tdata1_n.etrig.action = 6'd1;
        end
      end
      default: begin
        tdata1_n.raw = TDATA1_DISABLED;
      end
    endcase
  end

  // Etrigger keeps only implemented causes in tdata2
  assign tdata2_n = (tdata1_sel.etrig.ttype == TTYPE_ETRIGGER) ?
                    (wr_if.wdata & ETRIG_CAUSE_MASK) : wr_if.wdata;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tselect_q <= '0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        tdata1_q[i].raw <= TDATA1_DISABLED;
        tdata2_q[i]     <= '0;
      end
    end else begin
      if (wr_if.tselect_we && (wr_if.wdata < NUM_TRIGGERS)) begin
        tselect_q <= wr_if.wdata;  // Out of range writes are dropped
      end
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        if (wr_if.tdata1_we && (tselect_q == i)) begin
          tdata1_q[i] <= tdata1_n;
        end
        if (wr_if.tdata2_we && (tselect_q == i)) begin
          tdata2_q[i] <= tdata2_n;
        end
      end
    end
  end

  assign tdata1_q_o = tdata1_q;
  assign tdata2_q_o = tdata2_q;

  // Any tselect write leaves a legal index behind
  a_tselect_range: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wr_if.tselect_we |=> (tselect_q < NUM_TRIGGERS)
  );

endmodule

`default_nettype wire

// File: rtl/trig_csr_wr_if.sv
//////////////////////////////
// CSR write bundle into the trigger register bank
// Top level drives it, register bank reads it
//////////////////////////////
`default_nettype none

interface trig_csr_wr_if
  import dbg_trig_pkg::*;
;

  logic [XLEN-1:0] wdata;       // Shared write data
  logic            tselect_we;  // One-cycle strobes, never two at once
  logic            tdata1_we;
  logic            tdata2_we;

  modport master (output wdata, tselect_we, tdata1_we, tdata2_we);
  modport slave  (input  wdata, tselect_we, tdata1_we, tdata2_we);

endinterface

`default_nettype wire

// File: rtl/dbg_trig_pkg.sv
//////////////////////////////
// Shared types, tdata1 views and constants of the debug trigger unit
// Modules pull these in with a wildcard import in their header
//////////////////////////////
`default_nettype none

package dbg_trig_pkg;

  localparam int XLEN        = 32;  // CSR and address width
  localparam int EXC_CAUSE_W = 11;  // Width of the exception cause

  // Trigger type, lives in tdata1[31:28]
  typedef enum logic [3:0] {
    TTYPE_ETRIGGER  = 4'd5,   // Exception trigger
    TTYPE_MCONTROL6 = 4'd6,   // Address match trigger
    TTYPE_DISABLED  = 4'd15   // Trigger does nothing
  } ttype_e;

  // Address compare modes, the only legal match values
  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,  // Equal
    MATCH_GE = 4'd2,  // Greater or equal
    MATCH_LT = 4'd3   // Less than
  } match_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  //////////////////////////////
  // tdata1 register views
  //////////////////////////////

  typedef struct packed {
    ttype_e      ttype;     // 31:28
    logic        dmode;     // 27, debug mode access only
    logic [10:0] zero1;     // 26:16 hit, size and select, all zero here
    logic [3:0]  action;    // 15:12, 1 enters debug mode
    logic        chain;     // 11
    match_e      match;     // 10:7
    logic        m;         // 6, match in M mode
    logic [1:0]  zero0;     // 5:4
    logic        u;         // 3, match in U mode
    logic        execute;   // 2
    logic        store;     // 1
    logic        load;      // 0
  } mcontrol6_t;

  typedef struct packed {
    ttype_e      ttype;     // 31:28
    logic        dmode;     // 27
    logic [16:0] zero1;     // 26:10
    logic        m;         // 9
    logic [1:0]  zero0;     // 8:7
    logic        u;         // 6
    logic [5:0]  action;    // 5:0
  } etrigger_t;

  // Same tdata1 word, decoded by type
  typedef union packed {
    mcontrol6_t      mc6;
    etrigger_t       etrig;
    logic [XLEN-1:0] raw;
  } tdata1_u;

  localparam logic [XLEN-1:0] TDATA1_DISABLED  = 32'hF800_0000;  // Type 15, dmode 1
  localparam logic [XLEN-1:0] ETRIG_CAUSE_MASK = 32'h0100_09AE;  // Causes 1,2,3,5,7,8,11,24
  localparam logic [XLEN-1:0] TINFO_VALUE      = 32'h0100_8060;  // Types 5, 6, 15; version 1

  // Privilege enable check shared by all match units
  function automatic logic priv_enabled(input logic      m_en,
                                        input logic      u_en,
                                        input priv_lvl_t lvl);
    return (m_en && (lvl == PRIV_LVL_M)) || (u_en && (lvl == PRIV_LVL_U));
  endfunction

endpackage

`default_nettype wire
